// File: hdl/discrete_pkg.sv
//--------------------
// discrete audio package
// sample types, fixed-point format and the shared filter arithmetic.
//--------------------
package discrete_pkg;

    localparam int sample_width = 16;
    localparam int alpha_frac_bits = 16;

    typedef logic signed [sample_width-1:0] sample_t;
    typedef logic signed [39:0] acc_t;

    // smoothing factor in Q16 for one step at step_rate; c_q35 is farads << 35.
    function automatic int smoothing_alpha(input longint step_rate, input longint r_ohm,
                                           input longint c_q35);
        longint delta_t_q32;
        longint rc_q32;
        delta_t_q32 = (longint'(1) << 32) / step_rate;
        rc_q32 = (r_ohm * c_q35) >>> 3;    // Q35 down to Q32.
        return int'((delta_t_q32 << alpha_frac_bits) / (rc_q32 + delta_t_q32));
    endfunction

    // prev + alpha * (x - prev), fraction dropped by arithmetic shift.
    function automatic sample_t smooth_step(input sample_t prev, input sample_t x,
                                            input int alpha);
        acc_t diff;
        acc_t prod;
        diff = acc_t'(x) - acc_t'(prev);
        prod = acc_t'(alpha) * diff;
        return sample_t'(acc_t'(prev) + (prod >>> alpha_frac_bits));
    endfunction

    function automatic sample_t saturate(input acc_t value);
        if (value > acc_t'(32767))
            return sample_t'(32767);
        if (value < acc_t'(-32768))
            return sample_t'(-32768);
        return sample_t'(value);
    endfunction

endpackage

// File: hdl/audio_tick_gen.sv
//--------------------
// audio tick generator
// one-cycle sample enable every clock_rate / sample_rate clocks.
//--------------------
`timescale 1ns/1ps

module audio_tick_gen #(
    parameter int clock_rate = 1000000,
    parameter int sample_rate = 50000
) (
    input  logic clk,
    input  logic reset,
    output logic sample_tick
);

    localparam int cycles_per_sample = clock_rate / sample_rate;
    localparam int count_width = $clog2(cycles_per_sample);

    logic [count_width-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= count_width'(cycles_per_sample - 1);
            sample_tick <= 1'b0;
        end else if (count == '0) begin
            count <= count_width'(cycles_per_sample - 1);  // wrap and reload.
            sample_tick <= 1'b1;
        end else begin
            count <= count - 1'b1;
            sample_tick <= 1'b0;
        end
    end

    // no tick within a sample period of the previous one.
    for (genvar k = 1; k < cycles_per_sample; k++) begin : g_spacing
        assert property (@(posedge clk) disable iff (reset)
            sample_tick |-> !$past(sample_tick, k));
    end

endmodule

// File: hdl/rc_low_pass.sv
//--------------------
// rc low-pass filter
// first-order RC smoothing, oversampled on the idle clocks between samples.
//--------------------
`timescale 1ns/1ps

module rc_low_pass
    import discrete_pkg::*;
#(
    parameter int clock_rate = 1000000,
    parameter int sample_rate = 50000,
    parameter int oversample = 8,
    parameter int r = 47000,
    parameter int c_q35 = 1615
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    sample_tick,
    input  sample_t in,
    output sample_t out
);

    localparam int cycles_per_sample = clock_rate / sample_rate;
    localparam int cnt_width = $clog2(oversample + 1);
    // each sub-step covers 1 / (sample_rate * oversample) seconds.
    localparam int alpha = smoothing_alpha(sample_rate * oversample, r, c_q35);

    sample_t in_hold;
    sample_t state;
    logic [cnt_width-1:0] step_cnt;

    // sample held for the sub-step chain.
    always_ff @(posedge clk) begin
        if (sample_tick)
            in_hold <= in;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= '0;
            out <= '0;
            step_cnt <= cnt_width'(oversample);    // idle until the first tick.
        end else if (sample_tick) begin
            out <= state;                          // result of the finished chain.
            step_cnt <= '0;
        end else if (step_cnt < cnt_width'(oversample)) begin
            state <= smooth_step(state, in_hold, alpha);
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // the whole sub-step chain has to fit between two ticks.
    assert property (@(posedge clk) disable iff (reset)
        sample_tick |-> step_cnt == cnt_width'(oversample))
        else $error("rc_low_pass: %0d sub-steps do not fit in %0d cycles",
                    oversample, cycles_per_sample);

endmodule

// File: hdl/rc_high_pass.sv
//--------------------
// rc high-pass filter
// input minus a tracked RC low-pass state, same sub-step scheme.
//--------------------
`timescale 1ns/1ps

module rc_high_pass
    import discrete_pkg::*;
#(
    parameter int clock_rate = 1000000,
    parameter int sample_rate = 50000,
    parameter int oversample = 8,
    parameter int r = 10000,
    parameter int c_q35 = 3436
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    sample_tick,
    input  sample_t in,
    output sample_t out
);

    localparam int cycles_per_sample = clock_rate / sample_rate;
    localparam int cnt_width = $clog2(oversample + 1);
    localparam int alpha = smoothing_alpha(sample_rate * oversample, r, c_q35);

    sample_t in_hold;
    sample_t lp_state;
    logic [cnt_width-1:0] step_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_hold <= '0;
            lp_state <= '0;
            out <= '0;
            step_cnt <= cnt_width'(oversample);
        end else if (sample_tick) begin
            // held sample minus its smoothed tracking.
            out <= saturate(acc_t'(in_hold) - acc_t'(lp_state));
            in_hold <= in;
            step_cnt <= '0;
        end else if (step_cnt < cnt_width'(oversample)) begin
            lp_state <= smooth_step(lp_state, in_hold, alpha);
            step_cnt <= step_cnt + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        sample_tick |-> step_cnt == cnt_width'(oversample))
        else $error("rc_high_pass: %0d sub-steps do not fit in %0d cycles",
                    oversample, cycles_per_sample);

endmodule

// File: hdl/sample_mixer.sv
//--------------------
// sample mixer
// weighted sum of both filter branches, saturated to 16 bits.
//--------------------
`timescale 1ns/1ps

module sample_mixer
    import discrete_pkg::*;
#(
    parameter int lp_gain = 192,   // Q8, 0.75.
    parameter int hp_gain = 64     // Q8, 0.25.
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    sample_tick,
    input  sample_t lp_in,
    input  sample_t hp_in,
    output sample_t out
);

    logic tick_d;
    acc_t mix_sum;

    // filters update on the tick edge, so sum the cycle after.
    always_ff @(posedge clk) begin
        if (reset)
            tick_d <= 1'b0;
        else
            tick_d <= sample_tick;
    end

    assign mix_sum = (acc_t'(lp_in) * acc_t'(lp_gain)
                    + acc_t'(hp_in) * acc_t'(hp_gain)) >>> 8;

    always_ff @(posedge clk) begin
        if (reset)
            out <= '0;
        else if (tick_d)
            out <= saturate(mix_sum);  // holds between samples.
    end

    // out only ever moves in the cycle after a tick.
    assert property (@(posedge clk) disable iff (reset)
        !$past(sample_tick, 2) |-> $stable(out));

endmodule

// File: hdl/discrete_audio_top.sv
//--------------------
// discrete audio top
// tick generator, low-pass and high-pass branches and the output mixer.
//--------------------
`timescale 1ns/1ps

module discrete_audio_top
    import discrete_pkg::*;
#(
    parameter int clock_rate = 1000000,
    parameter int sample_rate = 50000,
    parameter int oversample = 8,
    parameter int lp_r = 47000,
    parameter int lp_c_q35 = 1615,     // 47 nF.
    parameter int hp_r = 10000,
    parameter int hp_c_q35 = 3436,     // 100 nF.
    parameter int lp_gain = 192,
    parameter int hp_gain = 64
) (
    input  logic    clk,
    input  logic    reset,
    input  sample_t in,
    output logic    sample_tick,
    output sample_t out
);

    sample_t lp_out;
    sample_t hp_out;

    audio_tick_gen #(
        .clock_rate(clock_rate),
        .sample_rate(sample_rate)
    ) u_tick (
        .clk(clk),
        .reset(reset),
        .sample_tick(sample_tick)
    );

    rc_low_pass #(
        .clock_rate(clock_rate),
        .sample_rate(sample_rate),
        .oversample(oversample),
        .r(lp_r),
        .c_q35(lp_c_q35)
    ) u_low_pass (
        .clk(clk),
        .reset(reset),
        .sample_tick(sample_tick),
        .in(in),
        .out(lp_out)
    );

    rc_high_pass #(
        .clock_rate(clock_rate),
        .sample_rate(sample_rate),
        .oversample(oversample),
        .r(hp_r),
        .c_q35(hp_c_q35)
    ) u_high_pass (
        .clk(clk),
        .reset(reset),
        .sample_tick(sample_tick),
        .in(in),
        .out(hp_out)
    );

    sample_mixer #(
        .lp_gain(lp_gain),
        .hp_gain(hp_gain)
    ) u_mixer (
        .clk(clk),
        .reset(reset),
        .sample_tick(sample_tick),
        .lp_in(lp_out),
        .hp_in(hp_out),
        .out(out)
    );

endmodule

// File: verif/tb_discrete_audio.sv
//--------------------
// discrete audio testbench
// random and directed samples checked against a bit-exact model of the filters and mixer.
//--------------------
`timescale 1ns/1ps

module tb_discrete_audio
    import discrete_pkg::*;
();

    localparam int clock_rate = 1000000;
    localparam int sample_rate = 50000;
    localparam int oversample = 8;
    localparam int lp_r = 47000;
    localparam int lp_c_q35 = 1615;
    localparam int hp_r = 10000;
    localparam int hp_c_q35 = 3436;
    localparam int lp_gain = 192;
    localparam int hp_gain = 64;
    localparam int cycles_per_sample = clock_rate / sample_rate;
    localparam int tick_timeout = 4 * cycles_per_sample;

    logic    clk;
    logic    reset;
    sample_t in;
    logic    sample_tick;
    sample_t out;

    integer seed;
    int     errors;
    int     checks;
    int     test_errors;
    int     test_checks;
    int     tests_run;
    bit     timed_out;
    longint cycle_count;
    longint last_tick_cycle;
    int     last_interval;

    longint  lp_alpha;
    longint  hp_alpha;
    sample_t m_lp_state;   // low-pass branch state.
    sample_t m_hp_state;   // tracked low-pass inside the high-pass.
    sample_t m_hp_hold;    // sample held by the high-pass since the last tick.

    discrete_audio_top #(
        .clock_rate(clock_rate),
        .sample_rate(sample_rate),
        .oversample(oversample),
        .lp_r(lp_r),
        .lp_c_q35(lp_c_q35),
        .hp_r(hp_r),
        .hp_c_q35(hp_c_q35),
        .lp_gain(lp_gain),
        .hp_gain(hp_gain)
    ) dut (
        .clk(clk),
        .reset(reset),
        .in(in),
        .sample_tick(sample_tick),
        .out(out)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Q16 smoothing factor from the sub-step rate and the RC product.
    function automatic longint alpha_q16(input longint step_rate, input longint r_ohm,
                                         input longint c_q35);
        longint dt_q32;
        longint rc_q32;
        dt_q32 = (longint'(1) << 32) / step_rate;
        rc_q32 = (r_ohm * c_q35) >>> 3;   // Q35 to Q32.
        return (dt_q32 * 65536) / (rc_q32 + dt_q32);
    endfunction

    function automatic sample_t rc_step(input sample_t prev, input sample_t x,
                                        input longint alpha);
        longint acc;
        acc = longint'(prev) + ((alpha * (longint'(x) - longint'(prev))) >>> 16);
        return sample_t'(acc);
    endfunction

    function automatic sample_t clamp16(input longint v);
        if (v > 32767)
            return sample_t'(32767);
        if (v < -32768)
            return sample_t'(-32768);
        return sample_t'(v);
    endfunction

    // one sample period of the model; expected is out one clock after the capture edge.
    task automatic model_tick(input sample_t x, output sample_t expected);
        sample_t lp_o;
        sample_t hp_o;
        longint  mix;
        lp_o = m_lp_state;
        hp_o = clamp16(longint'(m_hp_hold) - longint'(m_hp_state));
        m_hp_hold = x;
        for (int i = 0; i < oversample; i++) begin
            m_lp_state = rc_step(m_lp_state, x, lp_alpha);
            m_hp_state = rc_step(m_hp_state, x, hp_alpha);
        end
        mix = (longint'(lp_o) * lp_gain + longint'(hp_o) * hp_gain) >>> 8;
        expected = clamp16(mix);
    endtask

    task automatic wait_tick();
        int waited;
        bit seen;
        waited = 0;
        seen = 1'b0;
        while (!seen && !timed_out) begin
            @(negedge clk);
            waited++;
            if (sample_tick === 1'b1) begin
                seen = 1'b1;
                last_interval = int'(cycle_count - last_tick_cycle);
                last_tick_cycle = cycle_count;
            end else if (waited >= tick_timeout) begin
                $display("timeout: no sample_tick within %0d cycles, at %t",
                         tick_timeout, $time);
                timed_out = 1'b1;
                test_errors++;
            end
        end
    endtask

    task automatic check_out(input sample_t expected);
        test_checks++;
        if (out !== expected) begin
            test_errors++;
            $display("** Error at %t: out expected %0d, got %0d", $time, expected, out);
        end
    endtask

    // in is captured on the rising edge after the tick is seen.
    task automatic sample_step(input sample_t next_in);
        sample_t expected;
        wait_tick();
        if (!timed_out) begin
            model_tick(in, expected);
            @(negedge clk);
            in = next_in;
            @(negedge clk);
            check_out(expected);
        end
    endtask

    task automatic check_interval();
        test_checks++;
        if (last_interval != cycles_per_sample) begin
            test_errors++;
            $display("** Error at %t: sample_tick interval expected %0d, got %0d",
                     $time, cycles_per_sample, last_interval);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        checks += test_checks;
        errors += test_errors;
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic test_reset();
        repeat (8) begin
            @(negedge clk);
            test_checks++;
            if (out !== '0) begin
                test_errors++;
                $display("** Error at %t: out expected 0, got %0d", $time, out);
            end
            if (sample_tick !== 1'b0) begin
                test_errors++;
                $display("** Error at %t: sample_tick expected 0, got %b", $time, sample_tick);
            end
        end
        reset = 1'b0;
        last_tick_cycle = cycle_count;   // first interval counts from release.
        sample_step(sample_t'(0));
        if (!timed_out)
            check_interval();
        end_test("reset");
    endtask

    task automatic test_spacing();
        for (int i = 0; i < 50 && !timed_out; i++) begin
            sample_step(sample_t'($random(seed)));
            if (!timed_out)
                check_interval();
        end
        end_test("tick spacing");
    endtask

    task automatic test_dc_step();
        for (int i = 0; i < 200 && !timed_out; i++)
            sample_step(sample_t'(8000));
        end_test("dc step");
    endtask

    task automatic test_random();
        for (int i = 0; i < 500 && !timed_out; i++)
            sample_step(sample_t'($random(seed)));
        end_test("random stream");
    endtask

    task automatic test_saturation();
        // pull the tracked high-pass state far negative so positive steps clamp.
        for (int i = 0; i < 50 && !timed_out; i++)
            sample_step(sample_t'(-32768));
        for (int i = 0; i < 100 && !timed_out; i++)
            sample_step((i % 2 == 0) ? sample_t'(32767) : sample_t'(-32768));
        end_test("saturation");
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk = 1'b0;
        reset = 1'b1;
        in = '0;
        seed = 23644;
        errors = 0;
        checks = 0;
        test_errors = 0;
        test_checks = 0;
        tests_run = 0;
        timed_out = 1'b0;
        cycle_count = 0;
        last_tick_cycle = 0;
        last_interval = 0;
        lp_alpha = alpha_q16(longint'(sample_rate) * oversample, lp_r, lp_c_q35);
        hp_alpha = alpha_q16(longint'(sample_rate) * oversample, hp_r, hp_c_q35);
        m_lp_state = '0;
        m_hp_state = '0;
        m_hp_hold = '0;

        test_reset();
        test_spacing();
        test_dc_step();
        test_random();
        test_saturation();

        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0 && !timed_out)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: build.f
hdl/discrete_pkg.sv
hdl/audio_tick_gen.sv
hdl/rc_low_pass.sv
hdl/rc_high_pass.sv
hdl/sample_mixer.sv
hdl/discrete_audio_top.sv
verif/tb_discrete_audio.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the discrete audio testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_discrete_audio -f build.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
